//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = nnLayerTb
FILELIST = src.f
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- src.f
verilog/nnPkg.sv
verilog/layerRegs.sv
verilog/paramStore.sv
verilog/layerCtrl.sv
verilog/neuronMac.sv
verilog/activationStore.sv
verilog/nnLayerTop.sv
verification/nnLayerChecker.sv
verification/nnLayerTb.sv

//--- verification/nnLayerChecker.sv
`timescale 1ns/100ps

module nnLayerChecker (
	input logic clk,
	input logic reset,
	input logic pready,
	input logic busy,
	input logic done,
	input logic start,
	input logic accLoad,
	input logic accEn,
	input logic resultWe
);
	logic [8:0] busyLen;	// busy cycles of the current run

	always_ff @(posedge clk)
	begin
		if (reset || !busy)
			busyLen <= '0;
		else
			busyLen <= busyLen + 1'b1;
	end

	// ------------------------------
	readyHigh: assert property (@(posedge clk) pready)
		else $error("pready dropped low");

	resetQuiet: assert property (@(posedge clk)
		reset |=> !busy && !done && !start && !accLoad && !accEn && !resultWe)
		else $error("control outputs active around reset");

	startRaisesBusy: assert property (@(posedge clk) disable iff (reset)
		start |=> busy && !done)
		else $error("start did not begin a run");

	runTooLong: assert property (@(posedge clk) disable iff (reset)
		busy |-> busyLen < 9'd321)
		else $error("busy held past 321 cycles");

	runLength: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> busyLen == 9'd321)
		else $error("busy length is not 321 cycles");

	doneAtEnd: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> $rose(done))
		else $error("done did not rise as busy fell");

	doneOnlyAtEnd: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $fell(busy))
		else $error("done rose while busy stayed");

	storeNotMac: assert property (@(posedge clk) disable iff (reset)
		resultWe |-> !accEn && $past(accEn))
		else $error("resultWe not right after the last MAC cycle");

endmodule

bind nnLayerTop nnLayerChecker chk0 (
	.clk(clk),
	.reset(reset),
	.pready(pready),
	.busy(busy),
	.done(done),
	.start(start),
	.accLoad(accLoad),
	.accEn(accEn),
	.resultWe(resultWe)
);

//--- verification/nnLayerTb.sv
`timescale 1ns/100ps

module nnLayerTb;
	import nnPkg::*;

	logic clk;
	logic reset;
	apbAddr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apbData_t pwdata;
	apbData_t prdata;
	logic pready;
	logic pslverr;

	int wModel [NUM_NEURONS][NUM_INPUTS];
	int bModel [NUM_NEURONS];
	int xModel [NUM_INPUTS];

	nnLayerTop dut0 (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #2 clk = ~clk;

	// ------------------------------
	// checks and bus transfers
	task automatic checkValue(string name, apbData_t got, apbData_t exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// caller starts 1 ns past a clock edge
	task automatic apbXfer(input logic write, input apbAddr_t addr, input apbData_t wdata,
		input logic expErr, output apbData_t rdata);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2;	// mid access cycle
		checkValue("pslverr", apbData_t'(pslverr), apbData_t'(expErr));
		rdata = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic readCheck(apbAddr_t addr, apbData_t exp);
		apbData_t got;
		apbXfer(1'b0, addr, '0, 1'b0, got);
		checkValue($sformatf("prdata[0x%03h]", addr), got, exp);
	endtask

	function automatic apbAddr_t weightAddr(int n, int i);
		return apbAddr_t'(BASE_WEIGHT + 4 * (32 * n + i));
	endfunction

	function automatic int randByte();
		logic signed [7:0] b;
		b = 8'($urandom);
		return int'(b);
	endfunction

	task automatic loadInput(int i, int v);
		apbData_t rd;
		xModel[i] = v;
		apbXfer(1'b1, apbAddr_t'(BASE_INPUT + 4 * i), apbData_t'(v), 1'b0, rd);
	endtask

	task automatic loadBias(int n, int v);
		apbData_t rd;
		bModel[n] = v;
		apbXfer(1'b1, apbAddr_t'(BASE_BIAS + 4 * n), apbData_t'(v), 1'b0, rd);
	endtask

	task automatic loadWeight(int n, int i, int v);
		apbData_t rd;
		wModel[n][i] = v;
		apbXfer(1'b1, weightAddr(n, i), apbData_t'(v), 1'b0, rd);
	endtask

	// ------------------------------
	// reference model of relu and clip
	function automatic int expectedResult(int n);
		int sum;
		sum = bModel[n];
		for (int i = 0; i < NUM_INPUTS; i++)
			sum += wModel[n][i] * xModel[i];
		if (sum < 0)
			return 0;
		else if (sum > ACT_MAX)
			return ACT_MAX;
		return sum;
	endfunction

	task automatic checkResults();
		for (int n = 0; n < NUM_NEURONS; n++)
			readCheck(apbAddr_t'(BASE_RESULT + 4 * n), apbData_t'(expectedResult(n)));
	endtask

	task automatic checkParams();
		for (int i = 0; i < NUM_INPUTS; i++)
			readCheck(apbAddr_t'(BASE_INPUT + 4 * i), apbData_t'(xModel[i]));
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			readCheck(apbAddr_t'(BASE_BIAS + 4 * n), apbData_t'(bModel[n]));
			for (int i = 0; i < NUM_INPUTS; i++)
				readCheck(weightAddr(n, i), apbData_t'(wModel[n][i]));
		end
	endtask

	task automatic waitDone();
		apbData_t st;
		int polls;
		st = '0;
		polls = 0;
		while (!st[1])
		begin
			apbXfer(1'b0, ADDR_STATUS, '0, 1'b0, st);
			polls++;
			if (polls > 400)
			begin
				$display("timeout while polling STATUS for the done bit");
				$display("Simulation failed");
				$fatal(1);
			end
		end
	endtask

	// ------------------------------
	initial
	begin
		apbData_t rd;
		void'($urandom(32'hc89));
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		readCheck(ADDR_STATUS, 32'h0);
		checkResults();	// model is all zero here

		for (int i = 0; i < NUM_INPUTS; i++)
			loadInput(i, randByte());
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			loadBias(n, randByte());
			for (int i = 0; i < NUM_INPUTS; i++)
				loadWeight(n, i, randByte());
		end
		checkParams();

		// first run with illegal accesses while busy
		apbXfer(1'b1, ADDR_CTRL, 32'h1, 1'b0, rd);
		readCheck(ADDR_STATUS, 32'h1);
		apbXfer(1'b1, weightAddr(2, 5), 32'h55, 1'b1, rd);
		apbXfer(1'b1, apbAddr_t'(BASE_INPUT + 4 * 7), 32'h66, 1'b1, rd);
		apbXfer(1'b1, ADDR_CTRL, 32'h1, 1'b1, rd);
		apbXfer(1'b0, 12'h0f0, '0, 1'b1, rd);
		apbXfer(1'b1, 12'h0f0, 32'h1, 1'b1, rd);
		apbXfer(1'b0, weightAddr(0, 30), '0, 1'b1, rd);	// hole past the last input
		waitDone();
		readCheck(ADDR_STATUS, 32'h2);
		checkResults();
		checkParams();

		// neuron 0 saturates high, neuron 1 goes negative, neuron 2 lands in range
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			loadInput(i, i + 1);
			loadWeight(0, i, 127);
			loadWeight(1, i, -128);
			loadWeight(2, i, (i % 2 == 0) ? -1 : 1);
		end
		loadBias(1, -128);
		loadBias(2, 50);
		apbXfer(1'b1, ADDR_CTRL, 32'h1, 1'b0, rd);
		readCheck(ADDR_STATUS, 32'h1);	// done cleared by the new start
		waitDone();
		readCheck(ADDR_STATUS, 32'h2);
		readCheck(BASE_RESULT, 32'd127);
		readCheck(apbAddr_t'(BASE_RESULT + 4), 32'd0);
		readCheck(apbAddr_t'(BASE_RESULT + 8), 32'd65);	// 15 pairs of -odd plus even, bias 50
		checkResults();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- verilog/activationStore.sv
`timescale 1ns/100ps

module activationStore (
	input logic clk,
	input logic reset,
	input logic resultWe,
	input nnPkg::neuronIdx_t neuronSel,
	input nnPkg::accum_t acc,
	input nnPkg::neuronIdx_t readSel,
	output nnPkg::activation_t result
);
	import nnPkg::*;

	activation_t resultMem [NUM_NEURONS];
	activation_t rectified;

	// relu, then clip to the 8 bit range
	always_comb
	begin
		if (acc < 0)
			rectified = '0;
		else if (acc > ACT_MAX)
			rectified = activation_t'(ACT_MAX);
		else
			rectified = acc[7:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
				resultMem[n] <= '0;
		end
		else if (resultWe)
			resultMem[neuronSel] <= rectified;
	end

	// readSel comes straight from the bus address
	assign result = (int'(readSel) < NUM_NEURONS) ? resultMem[readSel] : '0;

endmodule

//--- verilog/layerCtrl.sv
`timescale 1ns/100ps

module layerCtrl (
	input logic clk,
	input logic reset,
	input logic start,
	output logic busy,
	output logic done,
	output nnPkg::neuronIdx_t neuronSel,
	output nnPkg::inputIdx_t inputSel,
	output logic accLoad,
	output logic accEn,
	output logic resultWe
);
	import nnPkg::*;

	localparam neuronIdx_t LAST_NEURON = neuronIdx_t'(NUM_NEURONS - 1);
	localparam inputIdx_t LAST_INPUT = inputIdx_t'(NUM_INPUTS - 1);

	ctrlState_t state;

	// ------------------------------
	// sequencing
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			neuronSel <= '0;
			inputSel <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= BIAS;
						neuronSel <= '0;
						inputSel <= '0;
						done <= 1'b0;	// cleared by each new run
					end
				end
				BIAS:
					state <= MAC;
				MAC:
				begin
					if (inputSel == LAST_INPUT)
					begin
						inputSel <= '0;
						state <= STORE;
					end
					else
						inputSel <= inputSel + 1'b1;
				end
				STORE:
				begin
					if (neuronSel == LAST_NEURON)
					begin
						neuronSel <= '0;
						state <= FINISH;
					end
					else
					begin
						neuronSel <= neuronSel + 1'b1;
						state <= BIAS;
					end
				end
				FINISH:
				begin
					done <= 1'b1;
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// 10 * (1 + 30 + 1) + 1 = 321 busy cycles
	assign busy = (state != IDLE);
	assign accLoad = (state == BIAS);
	assign accEn = (state == MAC);
	assign resultWe = (state == STORE);

endmodule

//--- verilog/layerRegs.sv
`timescale 1ns/100ps

module layerRegs (
	input logic clk,
	input logic reset,
	input nnPkg::apbAddr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input nnPkg::apbData_t pwdata,
	output nnPkg::apbData_t prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic done,
	output logic start,
	output logic paramWe,
	output nnPkg::apbAddr_t paramAddr,
	output nnPkg::weight_t paramWdata,
	input nnPkg::weight_t paramRdata,
	input nnPkg::activation_t result,
	output nnPkg::neuronIdx_t readSel
);
	import nnPkg::*;

	logic setupPhase;
	logic accessPhase;
	logic aligned;
	logic ctrlHit;
	logic statusHit;
	logic paramHit;
	logic resultHit;
	logic hitCtrl;
	logic hitStatus;
	logic hitParam;
	logic hitResult;
	logic mapped;
	logic writeErr;

	assign setupPhase = psel && !penable;
	assign accessPhase = psel && penable;

	// ------------------------------
	// address decode
	assign aligned = (paddr[1:0] == 2'b00);
	assign ctrlHit = (paddr == ADDR_CTRL);
	assign statusHit = (paddr == ADDR_STATUS);
	assign paramHit = aligned && (inRegion(paddr, BASE_INPUT, NUM_INPUTS)
		|| inRegion(paddr, BASE_BIAS, NUM_NEURONS) || isWeightAddr(paddr));
	assign resultHit = aligned && inRegion(paddr, BASE_RESULT, NUM_NEURONS);

	assign readSel = neuronIdx_t'(regionIdx(paddr, BASE_RESULT));

	// decode and read data are captured in setup, address is stable through access
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hitCtrl <= 1'b0;
			hitStatus <= 1'b0;
			hitParam <= 1'b0;
			hitResult <= 1'b0;
		end
		else if (setupPhase)
		begin
			hitCtrl <= ctrlHit;
			hitStatus <= statusHit;
			hitParam <= paramHit;
			hitResult <= resultHit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (setupPhase)
		begin
			if (statusHit)
				prdata <= {30'b0, done, busy};
			else if (paramHit)
				prdata <= {{24{paramRdata[7]}}, paramRdata};	// sign extend
			else if (resultHit)
				prdata <= {{24{result[7]}}, result};
			else
				prdata <= '0;	// ctrl reads back zero
		end
	end

	// ------------------------------
	// access phase response
	assign mapped = hitCtrl || hitStatus || hitParam || hitResult;
	assign writeErr = pwrite && (hitStatus || hitResult || (hitParam && busy)
		|| (hitCtrl && pwdata[0] && busy));

	assign pready = 1'b1;
	assign pslverr = accessPhase && (!mapped || writeErr);

	assign start = accessPhase && pwrite && hitCtrl && pwdata[0] && !busy;
	assign paramWe = accessPhase && pwrite && hitParam && !busy;
	assign paramAddr = paddr;
	assign paramWdata = pwdata[7:0];

endmodule

//--- verilog/neuronMac.sv
`timescale 1ns/100ps

module neuronMac (
	input logic clk,
	input logic reset,
	input logic accLoad,
	input logic accEn,
	input nnPkg::weight_t bias,
	input nnPkg::weight_t weight,
	input nnPkg::activation_t activation,
	output nnPkg::accum_t acc
);
	import nnPkg::*;

	product_t product;

	assign product = weight * activation;	// signed 8x8

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (accLoad)
			acc <= accum_t'(bias);	// sign extended
		else if (accEn)
			acc <= acc + accum_t'(product);
	end

endmodule

//--- verilog/nnLayerTop.sv
`timescale 1ns/100ps

module nnLayerTop (
	input logic clk,
	input logic reset,
	input nnPkg::apbAddr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input nnPkg::apbData_t pwdata,
	output nnPkg::apbData_t prdata,
	output logic pready,
	output logic pslverr
);
	import nnPkg::*;

	logic start;
	logic busy;
	logic done;
	logic paramWe;
	logic accLoad;
	logic accEn;
	logic resultWe;
	apbAddr_t paramAddr;
	weight_t paramWdata;
	weight_t paramRdata;
	weight_t weight;
	weight_t bias;
	activation_t activation;
	activation_t result;
	neuronIdx_t neuronSel;
	neuronIdx_t readSel;
	inputIdx_t inputSel;
	accum_t acc;

	// ------------------------------
	// host side
	layerRegs regs0 (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done), .start(start),
		.paramWe(paramWe), .paramAddr(paramAddr), .paramWdata(paramWdata),
		.paramRdata(paramRdata), .result(result), .readSel(readSel)
	);

	paramStore store0 (
		.clk(clk), .reset(reset),
		.paramWe(paramWe), .paramAddr(paramAddr), .paramWdata(paramWdata),
		.paramRdata(paramRdata),
		.neuronSel(neuronSel), .inputSel(inputSel),
		.weight(weight), .bias(bias), .activation(activation)
	);

	// ------------------------------
	// compute side
	layerCtrl ctrl0 (
		.clk(clk), .reset(reset),
		.start(start), .busy(busy), .done(done),
		.neuronSel(neuronSel), .inputSel(inputSel),
		.accLoad(accLoad), .accEn(accEn), .resultWe(resultWe)
	);

	neuronMac mac0 (
		.clk(clk), .reset(reset),
		.accLoad(accLoad), .accEn(accEn),
		.bias(bias), .weight(weight), .activation(activation),
		.acc(acc)
	);

	activationStore act0 (
		.clk(clk), .reset(reset),
		.resultWe(resultWe), .neuronSel(neuronSel), .acc(acc),
		.readSel(readSel), .result(result)
	);

endmodule

//--- verilog/nnPkg.sv
package nnPkg;

	// ------------------------------
	// datapath widths
	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] product_t;
	typedef logic signed [19:0] accum_t;	// 30 * 128 * 128 + 128 fits in 20 bits
	typedef logic [3:0] neuronIdx_t;
	typedef logic [4:0] inputIdx_t;
	typedef logic [11:0] apbAddr_t;
	typedef logic [31:0] apbData_t;

	localparam int NUM_NEURONS = 10;
	localparam int NUM_INPUTS = 30;
	localparam int ACT_MAX = 127;

	// ------------------------------
	// address map
	localparam apbAddr_t ADDR_CTRL = 12'h000;
	localparam apbAddr_t ADDR_STATUS = 12'h004;
	localparam apbAddr_t BASE_INPUT = 12'h100;
	localparam apbAddr_t BASE_BIAS = 12'h200;
	localparam apbAddr_t BASE_RESULT = 12'h300;
	localparam apbAddr_t BASE_WEIGHT = 12'h400;
	localparam int WEIGHT_STRIDE = 32;	// words per weight row

	typedef enum logic [2:0] {IDLE, BIAS, MAC, STORE, FINISH} ctrlState_t;

	// true when a falls inside a region of the given number of words
	function automatic logic inRegion(apbAddr_t a, apbAddr_t base, int words);
		return (int'(a) >= int'(base)) && (int'(a) < int'(base) + 4 * words);
	endfunction

	// word index within a flat region
	function automatic inputIdx_t regionIdx(apbAddr_t a, apbAddr_t base);
		apbAddr_t off;
		off = a - base;
		return off[6:2];
	endfunction

	function automatic neuronIdx_t weightRow(apbAddr_t a);
		apbAddr_t off;
		off = a - BASE_WEIGHT;
		return off[10:7];	// 32 word stride
	endfunction

	function automatic inputIdx_t weightCol(apbAddr_t a);
		apbAddr_t off;
		off = a - BASE_WEIGHT;
		return off[6:2];
	endfunction

	// columns 30 and 31 of each row are holes
	function automatic logic isWeightAddr(apbAddr_t a);
		return inRegion(a, BASE_WEIGHT, NUM_NEURONS * WEIGHT_STRIDE)
			&& (int'(weightCol(a)) < NUM_INPUTS);
	endfunction

endpackage

//--- verilog/paramStore.sv
`timescale 1ns/100ps

module paramStore (
	input logic clk,
	input logic reset,
	input logic paramWe,
	input nnPkg::apbAddr_t paramAddr,
	input nnPkg::weight_t paramWdata,
	output nnPkg::weight_t paramRdata,
	input nnPkg::neuronIdx_t neuronSel,
	input nnPkg::inputIdx_t inputSel,
	output nnPkg::weight_t weight,
	output nnPkg::weight_t bias,
	output nnPkg::activation_t activation
);
	import nnPkg::*;

	weight_t weightMem [NUM_NEURONS][NUM_INPUTS];
	weight_t biasMem [NUM_NEURONS];
	activation_t inputMem [NUM_INPUTS];

	logic isInput;
	logic isBias;
	logic isWeight;
	inputIdx_t hostIdx;
	neuronIdx_t wRow;
	inputIdx_t wCol;

	// only the region is decoded here
	assign isInput = inRegion(paramAddr, BASE_INPUT, NUM_INPUTS);
	assign isBias = inRegion(paramAddr, BASE_BIAS, NUM_NEURONS);
	assign isWeight = isWeightAddr(paramAddr);
	assign hostIdx = regionIdx(paramAddr, BASE_INPUT);	// same word bits for inputs and biases
	assign wRow = weightRow(paramAddr);
	assign wCol = weightCol(paramAddr);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				biasMem[n] <= '0;
				for (int i = 0; i < NUM_INPUTS; i++)
					weightMem[n][i] <= '0;
			end
			for (int i = 0; i < NUM_INPUTS; i++)
				inputMem[i] <= '0;
		end
		else if (paramWe)
		begin
			if (isInput)
				inputMem[hostIdx] <= paramWdata;
			else if (isBias)
				biasMem[neuronIdx_t'(hostIdx)] <= paramWdata;
			else if (isWeight)
				weightMem[wRow][wCol] <= paramWdata;
		end
	end

	// ------------------------------
	// host read port
	always_comb
	begin
		paramRdata = '0;
		if (isInput)
			paramRdata = inputMem[hostIdx];
		else if (isBias)
			paramRdata = biasMem[neuronIdx_t'(hostIdx)];
		else if (isWeight)
			paramRdata = weightMem[wRow][wCol];
	end

	// datapath read port
	assign weight = weightMem[neuronSel][inputSel];
	assign bias = biasMem[neuronSel];
	assign activation = inputMem[inputSel];

endmodule
